/* Makefile */
# Verilator flow for the kvs kernel control testbench

TOP := tb_kvs_kernel

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timescale 1ns/1ns --top-module kvs_kernel_top \
	  design/kvs_kernel_pkg.sv design/kvs_control_regs.sv design/run_timer.sv \
	  design/mem_addr_xlate.sv design/kvs_kernel_top.sv
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f tb.f

obj_dir/V$(TOP): tb.f design/*.sv test/*.sv
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f tb.f -o V$(TOP)

# the log decides pass or fail
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/kvs_control_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module kvs_control_regs (
  input  wire                                      ap_clk,
  input  wire                                      ap_rst_n,
  // axi4-lite slave
  input  wire                                      s_axi_control_awvalid,
  output wire                                      s_axi_control_awready,
  input  wire [kvs_kernel_pkg::ctrl_addr_w-1:0]    s_axi_control_awaddr,
  input  wire                                      s_axi_control_wvalid,
  output wire                                      s_axi_control_wready,
  input  wire [kvs_kernel_pkg::ctrl_data_w-1:0]    s_axi_control_wdata,
  input  wire [kvs_kernel_pkg::ctrl_data_w/8-1:0]  s_axi_control_wstrb,
  input  wire                                      s_axi_control_arvalid,
  output wire                                      s_axi_control_arready,
  input  wire [kvs_kernel_pkg::ctrl_addr_w-1:0]    s_axi_control_araddr,
  output logic                                     s_axi_control_rvalid,
  input  wire                                      s_axi_control_rready,
  output logic [kvs_kernel_pkg::ctrl_data_w-1:0]   s_axi_control_rdata,
  output wire  [1:0]                               s_axi_control_rresp,
  output logic                                     s_axi_control_bvalid,
  input  wire                                      s_axi_control_bready,
  output wire  [1:0]                               s_axi_control_bresp,
  // kernel control
  input  wire                                      ap_done,
  input  wire                                      ap_idle,
  output logic                                     ap_start,
  output wire  [kvs_kernel_pkg::mem_addr_w-1:0]    run_cycles,
  output wire  [kvs_kernel_pkg::mem_addr_w-1:0]    mem0_base,
  output wire  [kvs_kernel_pkg::mem_addr_w-1:0]    mem1_base
);

  logic [kvs_kernel_pkg::ctrl_data_w-1:0] cycles_lo;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] cycles_hi;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] mem0_lo;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] mem0_hi;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] mem1_lo;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] mem1_hi;

  logic                                   done_sticky;
  logic                                   rd_is_ctrl;  // pending read targets reg_ctrl
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] ctrl_word;
  logic [kvs_kernel_pkg::ctrl_data_w-1:0] rd_mux;
  logic                                   wr_fire;
  logic                                   rd_fire;
  logic                                   start_wr;

  // merge new data into a register under the byte strobes
  function automatic logic [kvs_kernel_pkg::ctrl_data_w-1:0] merge_bytes(
    input logic [kvs_kernel_pkg::ctrl_data_w-1:0]   old_val,
    input logic [kvs_kernel_pkg::ctrl_data_w-1:0]   new_val,
    input logic [kvs_kernel_pkg::ctrl_data_w/8-1:0] strb
  );
    logic [kvs_kernel_pkg::ctrl_data_w-1:0] res;
    res = old_val;
    for (int i = 0; i < kvs_kernel_pkg::ctrl_data_w / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////
  // write channel
  ////////////////////

  // address and data are taken together, only once the response slot is free
  assign wr_fire = s_axi_control_awvalid & s_axi_control_wvalid & ~s_axi_control_bvalid;
  assign s_axi_control_awready = wr_fire;
  assign s_axi_control_wready  = wr_fire;
  assign s_axi_control_bresp   = kvs_kernel_pkg::resp_okay;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cycles_lo <= '0;
      cycles_hi <= '0;
      mem0_lo   <= '0;
      mem0_hi   <= '0;
      mem1_lo   <= '0;
      mem1_hi   <= '0;
    end else if (wr_fire) begin
      case (s_axi_control_awaddr)
        kvs_kernel_pkg::reg_cycles_lo:
          cycles_lo <= merge_bytes(cycles_lo, s_axi_control_wdata, s_axi_control_wstrb);
        kvs_kernel_pkg::reg_cycles_hi:
          cycles_hi <= merge_bytes(cycles_hi, s_axi_control_wdata, s_axi_control_wstrb);
        kvs_kernel_pkg::reg_mem0_lo:
          mem0_lo <= merge_bytes(mem0_lo, s_axi_control_wdata, s_axi_control_wstrb);
        kvs_kernel_pkg::reg_mem0_hi:
          mem0_hi <= merge_bytes(mem0_hi, s_axi_control_wdata, s_axi_control_wstrb);
        kvs_kernel_pkg::reg_mem1_lo:
          mem1_lo <= merge_bytes(mem1_lo, s_axi_control_wdata, s_axi_control_wstrb);
        kvs_kernel_pkg::reg_mem1_hi:
          mem1_hi <= merge_bytes(mem1_hi, s_axi_control_wdata, s_axi_control_wstrb);
        default: ;  // control word handled below, rest ignored
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      s_axi_control_bvalid <= 1'b0;
    end else if (wr_fire) begin
      s_axi_control_bvalid <= 1'b1;
    end else if (s_axi_control_bready) begin
      s_axi_control_bvalid <= 1'b0;
    end
  end

  assign run_cycles = {cycles_hi, cycles_lo};
  assign mem0_base  = {mem0_hi, mem0_lo};
  assign mem1_base  = {mem1_hi, mem1_lo};

  ////////////////////
  // start and done
  ////////////////////

  assign start_wr = wr_fire
                  && (s_axi_control_awaddr == kvs_kernel_pkg::reg_ctrl)
                  && s_axi_control_wstrb[kvs_kernel_pkg::start_bit / 8]
                  && s_axi_control_wdata[kvs_kernel_pkg::start_bit];

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ap_start <= 1'b0;
    end else if (ap_done) begin
      ap_start <= 1'b0;
    end else if (start_wr && ap_idle) begin  // start only honoured when idle
      ap_start <= 1'b1;
    end
  end

  // only clear a done that the completing read actually returned
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      done_sticky <= 1'b0;
    end else if (ap_done) begin
      done_sticky <= 1'b1;
    end else if (s_axi_control_rvalid && s_axi_control_rready && rd_is_ctrl
                 && s_axi_control_rdata[kvs_kernel_pkg::done_bit]) begin
      done_sticky <= 1'b0;
    end
  end

  ////////////////////
  // read channel
  ////////////////////

  assign rd_fire = s_axi_control_arvalid & ~s_axi_control_rvalid;
  assign s_axi_control_arready = ~s_axi_control_rvalid;
  assign s_axi_control_rresp   = kvs_kernel_pkg::resp_okay;

  always_comb begin
    ctrl_word = '0;
    ctrl_word[kvs_kernel_pkg::start_bit] = ap_start;
    ctrl_word[kvs_kernel_pkg::done_bit]  = done_sticky;
    ctrl_word[kvs_kernel_pkg::idle_bit]  = ap_idle;
    case (s_axi_control_araddr)
      kvs_kernel_pkg::reg_ctrl:      rd_mux = ctrl_word;
      kvs_kernel_pkg::reg_cycles_lo: rd_mux = cycles_lo;
      kvs_kernel_pkg::reg_cycles_hi: rd_mux = cycles_hi;
      kvs_kernel_pkg::reg_mem0_lo:   rd_mux = mem0_lo;
      kvs_kernel_pkg::reg_mem0_hi:   rd_mux = mem0_hi;
      kvs_kernel_pkg::reg_mem1_lo:   rd_mux = mem1_lo;
      kvs_kernel_pkg::reg_mem1_hi:   rd_mux = mem1_hi;
      default:                       rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      s_axi_control_rvalid <= 1'b0;
      s_axi_control_rdata  <= '0;
      rd_is_ctrl           <= 1'b0;
    end else if (rd_fire) begin
      s_axi_control_rvalid <= 1'b1;
      s_axi_control_rdata  <= rd_mux;
      rd_is_ctrl           <= (s_axi_control_araddr == kvs_kernel_pkg::reg_ctrl);
    end else if (s_axi_control_rready) begin
      s_axi_control_rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/kvs_kernel_pkg.sv */
`default_nettype none

package kvs_kernel_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  localparam int ctrl_addr_w  = 12;  // axi-lite byte address
  localparam int ctrl_data_w  = 32;
  localparam int local_addr_w = 34;  // address as the kernel core sees it
  localparam int mem_addr_w   = 64;  // full memory address and base pointers

  ////////////////////
  // register map
  ////////////////////

  localparam logic [ctrl_addr_w-1:0] reg_ctrl      = 12'h000;
  localparam logic [ctrl_addr_w-1:0] reg_cycles_lo = 12'h010;  // run length, low word
  localparam logic [ctrl_addr_w-1:0] reg_cycles_hi = 12'h014;
  localparam logic [ctrl_addr_w-1:0] reg_mem0_lo   = 12'h018;  // channel 0 base pointer
  localparam logic [ctrl_addr_w-1:0] reg_mem0_hi   = 12'h01c;
  localparam logic [ctrl_addr_w-1:0] reg_mem1_lo   = 12'h020;  // channel 1 base pointer
  localparam logic [ctrl_addr_w-1:0] reg_mem1_hi   = 12'h024;

  // bit positions inside the control word
  localparam int start_bit = 0;
  localparam int done_bit  = 1;  // sticky, cleared on read
  localparam int idle_bit  = 2;

  localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

/* design/kvs_kernel_top.sv */
`timescale 1ns/1ns
`default_nettype none

module kvs_kernel_top (
  input  wire                                     ap_clk,
  input  wire                                     ap_rst_n,
  // axi4-lite control
  input  wire                                     s_axi_control_awvalid,
  output wire                                     s_axi_control_awready,
  input  wire [kvs_kernel_pkg::ctrl_addr_w-1:0]   s_axi_control_awaddr,
  input  wire                                     s_axi_control_wvalid,
  output wire                                     s_axi_control_wready,
  input  wire [kvs_kernel_pkg::ctrl_data_w-1:0]   s_axi_control_wdata,
  input  wire [kvs_kernel_pkg::ctrl_data_w/8-1:0] s_axi_control_wstrb,
  input  wire                                     s_axi_control_arvalid,
  output wire                                     s_axi_control_arready,
  input  wire [kvs_kernel_pkg::ctrl_addr_w-1:0]   s_axi_control_araddr,
  output wire                                     s_axi_control_rvalid,
  input  wire                                     s_axi_control_rready,
  output wire [kvs_kernel_pkg::ctrl_data_w-1:0]   s_axi_control_rdata,
  output wire [1:0]                               s_axi_control_rresp,
  output wire                                     s_axi_control_bvalid,
  input  wire                                     s_axi_control_bready,
  output wire [1:0]                               s_axi_control_bresp,
  // local address requests
  input  wire [kvs_kernel_pkg::local_addr_w-1:0]  c0_aw_addr,
  input  wire                                     c0_aw_valid,
  output wire                                     c0_aw_ready,
  input  wire [kvs_kernel_pkg::local_addr_w-1:0]  c0_ar_addr,
  input  wire                                     c0_ar_valid,
  output wire                                     c0_ar_ready,
  input  wire [kvs_kernel_pkg::local_addr_w-1:0]  c1_aw_addr,
  input  wire                                     c1_aw_valid,
  output wire                                     c1_aw_ready,
  input  wire [kvs_kernel_pkg::local_addr_w-1:0]  c1_ar_addr,
  input  wire                                     c1_ar_valid,
  output wire                                     c1_ar_ready,
  // memory address channels
  output wire [kvs_kernel_pkg::mem_addr_w-1:0]    c0_s_axi_awaddr,
  output wire                                     c0_s_axi_awvalid,
  input  wire                                     c0_s_axi_awready,
  output wire [kvs_kernel_pkg::mem_addr_w-1:0]    c0_s_axi_araddr,
  output wire                                     c0_s_axi_arvalid,
  input  wire                                     c0_s_axi_arready,
  output wire [kvs_kernel_pkg::mem_addr_w-1:0]    c1_s_axi_awaddr,
  output wire                                     c1_s_axi_awvalid,
  input  wire                                     c1_s_axi_awready,
  output wire [kvs_kernel_pkg::mem_addr_w-1:0]    c1_s_axi_araddr,
  output wire                                     c1_s_axi_arvalid,
  input  wire                                     c1_s_axi_arready
);

  wire                                  ap_start;
  wire                                  ap_done;
  wire                                  ap_idle;
  wire [kvs_kernel_pkg::mem_addr_w-1:0] run_cycles;
  wire [kvs_kernel_pkg::mem_addr_w-1:0] mem0_base;
  wire [kvs_kernel_pkg::mem_addr_w-1:0] mem1_base;

  ////////////////////
  // control side
  ////////////////////

  kvs_control_regs u_ctrl (
    .ap_clk                (ap_clk),
    .ap_rst_n              (ap_rst_n),
    .s_axi_control_awvalid (s_axi_control_awvalid),
    .s_axi_control_awready (s_axi_control_awready),
    .s_axi_control_awaddr  (s_axi_control_awaddr),
    .s_axi_control_wvalid  (s_axi_control_wvalid),
    .s_axi_control_wready  (s_axi_control_wready),
    .s_axi_control_wdata   (s_axi_control_wdata),
    .s_axi_control_wstrb   (s_axi_control_wstrb),
    .s_axi_control_arvalid (s_axi_control_arvalid),
    .s_axi_control_arready (s_axi_control_arready),
    .s_axi_control_araddr  (s_axi_control_araddr),
    .s_axi_control_rvalid  (s_axi_control_rvalid),
    .s_axi_control_rready  (s_axi_control_rready),
    .s_axi_control_rdata   (s_axi_control_rdata),
    .s_axi_control_rresp   (s_axi_control_rresp),
    .s_axi_control_bvalid  (s_axi_control_bvalid),
    .s_axi_control_bready  (s_axi_control_bready),
    .s_axi_control_bresp   (s_axi_control_bresp),
    .ap_done               (ap_done),
    .ap_idle               (ap_idle),
    .ap_start              (ap_start),
    .run_cycles            (run_cycles),
    .mem0_base             (mem0_base),
    .mem1_base             (mem1_base)
  );

  run_timer u_timer (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .ap_start   (ap_start),
    .run_cycles (run_cycles),
    .ap_done    (ap_done),
    .ap_idle    (ap_idle)
  );

  ////////////////////
  // address translation
  ////////////////////

  // channel 0 streams use mem0_base
  mem_addr_xlate u_c0_aw (
    .ap_clk (ap_clk), .ap_rst_n (ap_rst_n), .base (mem0_base),
    .in_addr (c0_aw_addr), .in_valid (c0_aw_valid), .in_ready (c0_aw_ready),
    .out_addr (c0_s_axi_awaddr), .out_valid (c0_s_axi_awvalid),
    .out_ready (c0_s_axi_awready)
  );

  mem_addr_xlate u_c0_ar (
    .ap_clk (ap_clk), .ap_rst_n (ap_rst_n), .base (mem0_base),
    .in_addr (c0_ar_addr), .in_valid (c0_ar_valid), .in_ready (c0_ar_ready),
    .out_addr (c0_s_axi_araddr), .out_valid (c0_s_axi_arvalid),
    .out_ready (c0_s_axi_arready)
  );

  // channel 1 streams use mem1_base
  mem_addr_xlate u_c1_aw (
    .ap_clk (ap_clk), .ap_rst_n (ap_rst_n), .base (mem1_base),
    .in_addr (c1_aw_addr), .in_valid (c1_aw_valid), .in_ready (c1_aw_ready),
    .out_addr (c1_s_axi_awaddr), .out_valid (c1_s_axi_awvalid),
    .out_ready (c1_s_axi_awready)
  );

  mem_addr_xlate u_c1_ar (
    .ap_clk (ap_clk), .ap_rst_n (ap_rst_n), .base (mem1_base),
    .in_addr (c1_ar_addr), .in_valid (c1_ar_valid), .in_ready (c1_ar_ready),
    .out_addr (c1_s_axi_araddr), .out_valid (c1_s_axi_arvalid),
    .out_ready (c1_s_axi_arready)
  );

endmodule

`default_nettype wire

/* design/mem_addr_xlate.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_addr_xlate (
  input  wire                                     ap_clk,
  input  wire                                     ap_rst_n,
  input  wire  [kvs_kernel_pkg::mem_addr_w-1:0]   base,
  // local request side
  input  wire  [kvs_kernel_pkg::local_addr_w-1:0] in_addr,
  input  wire                                     in_valid,
  output wire                                     in_ready,
  // memory side
  output logic [kvs_kernel_pkg::mem_addr_w-1:0]   out_addr,
  output logic                                    out_valid,
  input  wire                                     out_ready
);

  logic                                  in_fire;
  logic [kvs_kernel_pkg::mem_addr_w-1:0] in_addr_ext;

  ////////////////////
  // handshake
  ////////////////////

  // take a new address when the slot is empty or draining this cycle
  assign in_ready = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;

  assign in_addr_ext = {{(kvs_kernel_pkg::mem_addr_w - kvs_kernel_pkg::local_addr_w){1'b0}},
                        in_addr};  // zero extend

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  ////////////////////
  // address add
  ////////////////////

  // sum wraps at 64 bits, base sampled at the input transfer
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      out_addr <= '0;
    end else if (in_fire) begin
      out_addr <= base + in_addr_ext;
    end
  end

endmodule

`default_nettype wire

/* design/run_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module run_timer (
  input  wire                                   ap_clk,
  input  wire                                   ap_rst_n,
  input  wire                                   ap_start,
  input  wire [kvs_kernel_pkg::mem_addr_w-1:0]  run_cycles,
  output logic                                  ap_done,
  output wire                                   ap_idle
);

  logic                                  start_d;  // ap_start one cycle late
  logic                                  start_rise;
  logic                                  running;
  logic [kvs_kernel_pkg::mem_addr_w-1:0] count;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_d <= 1'b0;
    end else begin
      start_d <= ap_start;
    end
  end

  assign start_rise = ap_start & ~start_d;

  ////////////////////
  // countdown
  ////////////////////

  // done comes one edge after the count reaches zero, so a run of n
  // cycles ends n + 2 cycles after start rises
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      running <= 1'b0;
      count   <= '0;
      ap_done <= 1'b0;
    end else if (start_rise) begin
      running <= 1'b1;
      count   <= run_cycles;
      ap_done <= 1'b0;
    end else if (running) begin
      if (count == '0) begin
        running <= 1'b0;
        ap_done <= 1'b1;  // single pulse
      end else begin
        count   <= count - 1'b1;
        ap_done <= 1'b0;
      end
    end else begin
      ap_done <= 1'b0;
    end
  end

  assign ap_idle = ~running;

endmodule

`default_nettype wire

/* tb.f */
design/kvs_kernel_pkg.sv
design/kvs_control_regs.sv
design/run_timer.sv
design/mem_addr_xlate.sv
design/kvs_kernel_top.sv
test/tb_kvs_kernel.sv

/* test/tb_kvs_kernel.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_kvs_kernel;

  localparam int timeout_cycles = 20000;  // a few thousand cycles of tests, with margin
  localparam int burst_len      = 40;     // addresses per stream, at most 64

  logic        ap_clk;
  logic        ap_rst_n;
  logic        s_axi_control_awvalid;
  wire         s_axi_control_awready;
  logic [11:0] s_axi_control_awaddr;
  logic        s_axi_control_wvalid;
  wire         s_axi_control_wready;
  logic [31:0] s_axi_control_wdata;
  logic [3:0]  s_axi_control_wstrb;
  logic        s_axi_control_arvalid;
  wire         s_axi_control_arready;
  logic [11:0] s_axi_control_araddr;
  wire         s_axi_control_rvalid;
  logic        s_axi_control_rready;
  wire  [31:0] s_axi_control_rdata;
  wire  [1:0]  s_axi_control_rresp;
  wire         s_axi_control_bvalid;
  logic        s_axi_control_bready;
  wire  [1:0]  s_axi_control_bresp;

  // stream order 0 c0_aw, 1 c0_ar, 2 c1_aw, 3 c1_ar
  logic [3:0][33:0] loc_addr;
  logic [3:0]       loc_valid;
  wire  [3:0]       loc_ready;
  wire  [3:0][63:0] mem_addr;
  wire  [3:0]       mem_valid;
  logic [3:0]       mem_ready;

  logic [31:0] rng_state;
  int          cycle_count;
  int          errors;
  int          test_errors_start;
  int          tests_passed;
  int          tests_failed;
  string       test_name;
  logic [31:0] shadow [6];      // data register model
  logic [11:0] reg_offs [6];
  logic [63:0] base_model [2];
  logic [63:0] exp_mem [4][64]; // expected addresses per stream, in order
  int          pushed [4];
  int          popped [4];

  kvs_kernel_top dut (
    .*,
    .c0_aw_addr (loc_addr[0]), .c0_aw_valid (loc_valid[0]), .c0_aw_ready (loc_ready[0]),
    .c0_ar_addr (loc_addr[1]), .c0_ar_valid (loc_valid[1]), .c0_ar_ready (loc_ready[1]),
    .c1_aw_addr (loc_addr[2]), .c1_aw_valid (loc_valid[2]), .c1_aw_ready (loc_ready[2]),
    .c1_ar_addr (loc_addr[3]), .c1_ar_valid (loc_valid[3]), .c1_ar_ready (loc_ready[3]),
    .c0_s_axi_awaddr (mem_addr[0]), .c0_s_axi_awvalid (mem_valid[0]),
    .c0_s_axi_awready (mem_ready[0]),
    .c0_s_axi_araddr (mem_addr[1]), .c0_s_axi_arvalid (mem_valid[1]),
    .c0_s_axi_arready (mem_ready[1]),
    .c1_s_axi_awaddr (mem_addr[2]), .c1_s_axi_awvalid (mem_valid[2]),
    .c1_s_axi_awready (mem_ready[2]),
    .c1_s_axi_araddr (mem_addr[3]), .c1_s_axi_arvalid (mem_valid[3]),
    .c1_s_axi_arready (mem_ready[3])
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] expected_ctrl(input bit start, input bit done, input bit idle);
    logic [31:0] w;
    w = 32'h0;
    w[kvs_kernel_pkg::start_bit] = start;
    w[kvs_kernel_pkg::done_bit]  = done;
    w[kvs_kernel_pkg::idle_bit]  = idle;
    return w;
  endfunction

  // all stimulus changes land 10 ns after the rising edge
  task automatic tick();
    @(posedge ap_clk);
    #10;
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error in %s: %s", test_name, what);
    errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors_start = errors;
  endtask

  task automatic finish_test();
    if (errors == test_errors_start) begin
      $display("test %s: passed", test_name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - test_errors_start);
      tests_failed++;
    end
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_axi_control_awvalid = 1'b1;
    s_axi_control_awaddr  = addr;
    s_axi_control_wvalid  = 1'b1;
    s_axi_control_wdata   = data;
    s_axi_control_wstrb   = strb;
    @(negedge ap_clk);
    while (!(s_axi_control_awready && s_axi_control_wready)) @(negedge ap_clk);
    tick();
    s_axi_control_awvalid = 1'b0;
    s_axi_control_wvalid  = 1'b0;
    s_axi_control_bready  = 1'b1;
    @(negedge ap_clk);
    while (!s_axi_control_bvalid) @(negedge ap_clk);
    if (s_axi_control_bresp !== kvs_kernel_pkg::resp_okay)
      report_mismatch("write response", 64'(kvs_kernel_pkg::resp_okay), 64'(s_axi_control_bresp));
    tick();
    s_axi_control_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    s_axi_control_arvalid = 1'b1;
    s_axi_control_araddr  = addr;
    @(negedge ap_clk);
    while (!s_axi_control_arready) @(negedge ap_clk);
    tick();
    s_axi_control_arvalid = 1'b0;
    s_axi_control_rready  = 1'b1;
    @(negedge ap_clk);
    while (!s_axi_control_rvalid) @(negedge ap_clk);
    data = s_axi_control_rdata;
    if (s_axi_control_rresp !== kvs_kernel_pkg::resp_okay)
      report_mismatch("read response", 64'(kvs_kernel_pkg::resp_okay), 64'(s_axi_control_rresp));
    tick();
    s_axi_control_rready = 1'b0;
  endtask

  task automatic set_base(input int chan, input logic [63:0] value);
    axi_write(chan == 0 ? kvs_kernel_pkg::reg_mem0_lo : kvs_kernel_pkg::reg_mem1_lo,
              value[31:0], 4'hf);
    axi_write(chan == 0 ? kvs_kernel_pkg::reg_mem0_hi : kvs_kernel_pkg::reg_mem1_hi,
              value[63:32], 4'hf);
    base_model[chan] = value;
  endtask

  ////////////////////
  // kernel runs
  ////////////////////

  task automatic run_and_check(input int n);
    int          polls;
    bit          busy_seen;
    bit          done_seen;
    logic [31:0] rd;
    polls     = 0;
    busy_seen = 1'b0;
    done_seen = 1'b0;
    axi_write(kvs_kernel_pkg::reg_cycles_lo, n, 4'hf);
    axi_write(kvs_kernel_pkg::reg_cycles_hi, 32'h0, 4'hf);
    axi_write(kvs_kernel_pkg::reg_ctrl, expected_ctrl(1'b1, 1'b0, 1'b0), 4'hf);
    while (!done_seen && polls < 100) begin
      axi_read(kvs_kernel_pkg::reg_ctrl, rd);
      polls++;
      if (!rd[kvs_kernel_pkg::idle_bit]) busy_seen = 1'b1;
      if (rd[kvs_kernel_pkg::done_bit]) begin
        done_seen = 1'b1;
        if (rd !== expected_ctrl(1'b0, 1'b1, 1'b1))
          report_mismatch("control word at done", 64'(expected_ctrl(1'b0, 1'b1, 1'b1)), 64'(rd));
      end
    end
    if (!done_seen) report_failure($sformatf("done never read as set for %0d cycles", n));
    if (!busy_seen) report_failure("idle never read low during the run");
    axi_read(kvs_kernel_pkg::reg_ctrl, rd);
    if (rd !== expected_ctrl(1'b0, 1'b0, 1'b1))
      report_mismatch("control word after done", 64'(expected_ctrl(1'b0, 1'b0, 1'b1)), 64'(rd));
  endtask

  ////////////////////
  // address streams
  ////////////////////

  task automatic stream_burst(input int count);
    int          issued [4];
    logic [31:0] r;
    logic [3:0]  took;
    bit          busy;
    for (int ch = 0; ch < 4; ch++) begin
      issued[ch] = 0;
      pushed[ch] = 0;
      popped[ch] = 0;
    end
    took = 4'b0000;
    busy = 1'b1;
    while (busy) begin
      for (int ch = 0; ch < 4; ch++) begin
        r = next_rand();
        if (took[ch]) loc_valid[ch] = 1'b0;
        if (!loc_valid[ch] && issued[ch] < count && r[0]) begin
          loc_addr[ch]  = {r[9:8], next_rand()};
          loc_valid[ch] = 1'b1;
          issued[ch]++;
        end
        mem_ready[ch] = (r[3:2] != 2'b00);  // stall about one cycle in four
      end
      @(negedge ap_clk);
      busy = 1'b0;
      for (int ch = 0; ch < 4; ch++) begin
        if (mem_valid[ch] && mem_ready[ch]) begin
          if (popped[ch] == pushed[ch]) begin
            report_failure($sformatf("stream %0d sent an address nobody requested", ch));
          end else begin
            if (mem_addr[ch] !== exp_mem[ch][popped[ch]])
              report_mismatch($sformatf("stream %0d address %0d", ch, popped[ch]),
                              exp_mem[ch][popped[ch]], mem_addr[ch]);
            popped[ch]++;
          end
        end
        took[ch] = loc_valid[ch] && loc_ready[ch];
        if (took[ch]) begin
          exp_mem[ch][pushed[ch]] = base_model[ch / 2] + {30'd0, loc_addr[ch]};  // wraps
          pushed[ch]++;
        end
        if (popped[ch] < count) busy = 1'b1;
      end
      tick();
    end
    loc_valid = 4'b0000;
    mem_ready = 4'b1111;
    repeat (3) begin
      @(negedge ap_clk);
      if (mem_valid !== 4'b0000) report_failure("extra address after the burst drained");
    end
    tick();
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] r;
    logic [3:0]  strb;
    int          idx;
    int          n;
    int          done_count;
    rng_state             = 32'h23c0bd4c;
    errors                = 0;
    tests_passed          = 0;
    tests_failed          = 0;
    ap_rst_n              = 1'b0;
    s_axi_control_awvalid = 1'b0;
    s_axi_control_awaddr  = '0;
    s_axi_control_wvalid  = 1'b0;
    s_axi_control_wdata   = '0;
    s_axi_control_wstrb   = '0;
    s_axi_control_arvalid = 1'b0;
    s_axi_control_araddr  = '0;
    s_axi_control_rready  = 1'b0;
    s_axi_control_bready  = 1'b0;
    loc_addr              = '0;
    loc_valid             = '0;
    mem_ready             = '0;
    reg_offs[0] = kvs_kernel_pkg::reg_cycles_lo;
    reg_offs[1] = kvs_kernel_pkg::reg_cycles_hi;
    reg_offs[2] = kvs_kernel_pkg::reg_mem0_lo;
    reg_offs[3] = kvs_kernel_pkg::reg_mem0_hi;
    reg_offs[4] = kvs_kernel_pkg::reg_mem1_lo;
    reg_offs[5] = kvs_kernel_pkg::reg_mem1_hi;
    for (int i = 0; i < 6; i++) shadow[i] = 32'h0;  // registers clear on reset
    repeat (8) @(posedge ap_clk);
    #10;
    ap_rst_n = 1'b1;

    start_test("reset state");
    @(negedge ap_clk);
    if (mem_valid !== 4'b0000) report_mismatch("memory valid outputs", 64'h0, 64'(mem_valid));
    tick();
    axi_read(kvs_kernel_pkg::reg_ctrl, rd);
    if (rd !== expected_ctrl(1'b0, 1'b0, 1'b1))
      report_mismatch("control word", 64'(expected_ctrl(1'b0, 1'b0, 1'b1)), 64'(rd));
    finish_test();

    start_test("register readback");
    for (int i = 0; i < 30; i++) begin
      idx  = int'(next_rand() % 6);
      data = next_rand();
      r    = next_rand();
      strb = r[3:0];
      axi_write(reg_offs[idx], data, strb);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    for (int i = 0; i < 6; i++) begin
      axi_read(reg_offs[i], rd);
      if (rd !== shadow[i])
        report_mismatch($sformatf("register at %h", reg_offs[i]), 64'(shadow[i]), 64'(rd));
    end
    axi_read(12'h0f0, rd);  // unmapped
    if (rd !== 32'h0) report_mismatch("unmapped offset", 64'h0, 64'(rd));
    finish_test();

    start_test("run and done");
    for (int i = 0; i < 3; i++) begin
      n = int'(next_rand() % 41);
      run_and_check(n);
    end
    finish_test();

    start_test("start while running");
    n = 20 + int'(next_rand() % 20);
    axi_write(kvs_kernel_pkg::reg_cycles_lo, n, 4'hf);
    axi_write(kvs_kernel_pkg::reg_cycles_hi, 32'h0, 4'hf);
    axi_write(kvs_kernel_pkg::reg_ctrl, expected_ctrl(1'b1, 1'b0, 1'b0), 4'hf);
    axi_write(kvs_kernel_pkg::reg_ctrl, expected_ctrl(1'b1, 1'b0, 1'b0), 4'hf);
    done_count = 0;
    // window long enough for two runs back to back
    for (int i = 0; i < 60; i++) begin
      axi_read(kvs_kernel_pkg::reg_ctrl, rd);
      if (rd[kvs_kernel_pkg::done_bit]) done_count++;
    end
    if (done_count != 1) report_mismatch("done count", 64'd1, 64'(done_count));
    if (rd !== expected_ctrl(1'b0, 1'b0, 1'b1))
      report_mismatch("final control word", 64'(expected_ctrl(1'b0, 1'b0, 1'b1)), 64'(rd));
    finish_test();

    start_test("address translation");
    set_base(0, {next_rand(), next_rand()});
    set_base(1, {next_rand(), next_rand()});
    stream_burst(burst_len);
    finish_test();

    start_test("base change");
    set_base(0, {32'hffff_ffff, next_rand()});  // near the top so sums wrap
    stream_burst(burst_len / 2);
    finish_test();

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
